// ==== hw/spikeDefines.svh ====
`ifndef SPIKE_DEFINES_SVH
`define SPIKE_DEFINES_SVH

// PC word layout
`define PC_WIDTH 32
`define PC_CODE_WIDTH 8

// Generator array size
`define NUM_GENS 8
`define GEN_IDX_WIDTH 3

// Timing fields
`define PERIOD_WIDTH 16
`define UNIT_WIDTH 16

// Tag word fields, count saturates at all ones
`define TAG_WIDTH 11
`define COUNT_WIDTH 9

// Values after reset
`define UNIT_LEN_RESET 16'd0
`define GEN_PERIOD_RESET 16'd0
`define GEN_TAG_RESET 11'd0

`endif

// ==== hw/spikePkg.sv ====
`default_nettype none

`include "spikeDefines.svh"

package spikePkg;

  //////////////////////////////
  // PC opcodes

  // Upper byte of a PC word, anything else is dropped
  typedef enum logic [`PC_CODE_WIDTH-1:0] {
    opSetUnit   = 8'd1,
    opSetPeriod = 8'd2,
    opSetTag    = 8'd3,
    opSetEnable = 8'd4
  } pcOpcode_t;

  //////////////////////////////
  // Config bus fields

  // Which generator register a bus write targets
  typedef enum logic [1:0] {
    fieldPeriod,
    fieldTag,
    fieldEnable
  } cfgField_t;

  // Tag plus number of spikes it stands for
  typedef struct packed {
    logic [`TAG_WIDTH-1:0]   tag;
    logic [`COUNT_WIDTH-1:0] count;
  } tagWord_t;

endpackage

`default_nettype wire

// ==== hw/cfgBusIf.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spikeDefines.svh"

// Broadcast bus from the parser to every generator
interface cfgBusIf;

  // One-cycle strobe
  logic                      write;
  // Target generator
  logic [`GEN_IDX_WIDTH-1:0] index;
  spikePkg::cfgField_t       field;
  // Zero-extended for narrow fields
  logic [`PERIOD_WIDTH-1:0]  value;

  modport parser (output write, output index, output field, output value);

  // Each generator filters on its own index
  modport generator (input write, input index, input field, input value);

endinterface

`default_nettype wire

// ==== hw/tagChannelIf.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spikeDefines.svh"

// One generator's tag output toward the merger
interface tagChannelIf;

  // Held until accepted
  logic                valid;
  // Single-cycle accept
  logic                ack;
  // Stable while valid
  spikePkg::tagWord_t  word;

  // Generator side
  modport source (output valid, output word, input ack);

  // Merger side
  modport sink (input valid, input word, output ack);

endinterface

`default_nettype wire

// ==== hw/pcParser.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spikeDefines.svh"

// PC word decoder
// Strobes come out one cycle after the word arrives
module pcParser (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   pcValid,
  input  logic [`PC_WIDTH-1:0]   pcData,
  output logic                   unitWrite,
  output logic [`UNIT_WIDTH-1:0] unitLen,
  cfgBusIf.parser                cfg
);

  localparam int DataWidth = `PC_WIDTH - `PC_CODE_WIDTH;

  //////////////////////////////
  // Input register

  logic                 wordValid;
  logic [`PC_WIDTH-1:0] wordData;

  spikePkg::pcOpcode_t  opcode;
  logic [DataWidth-1:0] payload;

  // Word is taken every cycle, no back-pressure
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wordValid <= 1'b0;
    end else begin
      wordValid <= pcValid;
    end
  end

  // Payload only, qualified by wordValid
  always_ff @(posedge clk) begin
    if (pcValid) begin
      wordData <= pcData;
    end
  end

  //////////////////////////////
  // Decode

  // Split into opcode and data fields
  assign opcode  = spikePkg::pcOpcode_t'(wordData[`PC_WIDTH-1 -: `PC_CODE_WIDTH]);
  assign payload = wordData[DataWidth-1:0];

  // Unit length sits in the low data bits
  assign unitLen   = payload[`UNIT_WIDTH-1:0];
  assign unitWrite = wordValid && (opcode == spikePkg::opSetUnit);

  // Generator index in the top data bits
  assign cfg.index = payload[DataWidth-1 -: `GEN_IDX_WIDTH];

  always_comb begin
    cfg.write = 1'b0;
    cfg.field = spikePkg::fieldPeriod;
    cfg.value = '0;
    case (opcode)
      spikePkg::opSetPeriod: begin
        cfg.write = wordValid;
        cfg.field = spikePkg::fieldPeriod;
        cfg.value = payload[`PERIOD_WIDTH-1:0];
      end
      spikePkg::opSetTag: begin
        cfg.write = wordValid;
        cfg.field = spikePkg::fieldTag;
        cfg.value[`TAG_WIDTH-1:0] = payload[`TAG_WIDTH-1:0];
      end
      spikePkg::opSetEnable: begin
        cfg.write    = wordValid;
        cfg.field    = spikePkg::fieldEnable;
        cfg.value[0] = payload[0];
      end
      // opSetUnit handled above, unknown codes dropped
      default: begin
        cfg.write = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/timeMgr.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spikeDefines.svh"

// Time-unit pulse source
module timeMgr (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   unitWrite,
  input  logic [`UNIT_WIDTH-1:0] unitLen,
  output logic                   unitPulse
);

  // Programmed length, 0 means stopped
  logic [`UNIT_WIDTH-1:0] lenReg;
  // Clocks into current unit
  logic [`UNIT_WIDTH-1:0] clkCnt;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lenReg    <= `UNIT_LEN_RESET;
      clkCnt    <= '0;
      unitPulse <= 1'b0;
    end else if (unitWrite) begin
      // New length restarts the unit
      lenReg    <= unitLen;
      clkCnt    <= '0;
      unitPulse <= 1'b0;
    end else if (lenReg == '0) begin
      clkCnt    <= '0;
      unitPulse <= 1'b0;
    end else if (clkCnt >= lenReg - 1'b1) begin
      // Wrap, one pulse per unitLen clocks
      clkCnt    <= '0;
      unitPulse <= 1'b1;
    end else begin
      clkCnt    <= clkCnt + 1'b1;
      unitPulse <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/spikeGen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spikeDefines.svh"

// Periodic spike source with pending-count accumulation
module spikeGen #(
  parameter int genIndex = 0
) (
  input  logic        clk,
  input  logic        arstN,
  input  logic        unitPulse,
  cfgBusIf.generator  cfg,
  tagChannelIf.source tagOut
);

  localparam logic [`GEN_IDX_WIDTH-1:0] MyIndex = genIndex[`GEN_IDX_WIDTH-1:0];

  // Config registers
  logic [`PERIOD_WIDTH-1:0] period;
  logic [`TAG_WIDTH-1:0]    tag;
  logic                     enable;
  // Time units into the current period
  logic [`PERIOD_WIDTH-1:0] unitCnt;

  logic running;
  logic expire;
  logic transfer;
  spikePkg::tagWord_t pendWord;

  assign running  = enable && (period != '0);
  // Also catches a period shortened below the count
  assign expire   = unitPulse && running && (unitCnt >= period - 1'b1);
  assign transfer = tagOut.valid && tagOut.ack;

  //////////////////////////////
  // Config and period counter

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      period  <= `GEN_PERIOD_RESET;
      tag     <= `GEN_TAG_RESET;
      enable  <= 1'b0;
      unitCnt <= '0;
    end else begin
      if (cfg.write && (cfg.index == MyIndex)) begin
        case (cfg.field)
          spikePkg::fieldPeriod: period <= cfg.value;
          spikePkg::fieldTag:    tag    <= cfg.value[`TAG_WIDTH-1:0];
          spikePkg::fieldEnable: enable <= cfg.value[0];
          default:               enable <= enable;
        endcase
      end
      // Stopped generator restarts from zero, pending word kept
      if (!running || expire) begin
        unitCnt <= '0;
      end else if (unitPulse) begin
        unitCnt <= unitCnt + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Pending word

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      tagOut.valid <= 1'b0;
    end else if (expire) begin
      tagOut.valid <= 1'b1;
    end else if (transfer) begin
      tagOut.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (expire) begin
      if (tagOut.valid && !transfer) begin
        // Still waiting, bump count up to saturation
        if (pendWord.count != '1) begin
          pendWord.count <= pendWord.count + 1'b1;
        end
      end else begin
        pendWord.tag   <= tag;
        pendWord.count <= `COUNT_WIDTH'(1);
      end
    end
  end

  assign tagOut.word = pendWord;

endmodule

`default_nettype wire

// ==== hw/tagMerge.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spikeDefines.svh"

// Round-robin merge of all generator channels
module tagMerge (
  input  logic                                 clk,
  input  logic                                 arstN,
  tagChannelIf.sink                            tagIn [`NUM_GENS],
  output logic                                 tagValid,
  output logic [`TAG_WIDTH+`COUNT_WIDTH-1:0]   tagData,
  input  logic                                 tagAck
);

  logic [`NUM_GENS-1:0] validVec;
  logic [`NUM_GENS-1:0] ackVec;
  spikePkg::tagWord_t   wordVec [`NUM_GENS];

  // Search start, one past last winner
  logic [`GEN_IDX_WIDTH-1:0] ptr;
  logic [`GEN_IDX_WIDTH-1:0] winner;
  logic                      found;
  logic                      grant;
  spikePkg::tagWord_t        outWord;

  // Flatten the channel array for indexed access
  for (genvar i = 0; i < `NUM_GENS; i++) begin : gChan
    assign validVec[i]  = tagIn[i].valid;
    assign wordVec[i]   = tagIn[i].word;
    assign tagIn[i].ack = ackVec[i];
  end

  //////////////////////////////
  // Arbitration

  // First valid channel at or after ptr, index wraps
  always_comb begin
    logic [`GEN_IDX_WIDTH-1:0] idx;
    found  = 1'b0;
    winner = ptr;
    for (int k = 0; k < `NUM_GENS; k++) begin
      idx = ptr + k[`GEN_IDX_WIDTH-1:0];
      if (!found && validVec[idx]) begin
        found  = 1'b1;
        winner = idx;
      end
    end
  end

  // Load when output empty or draining this cycle
  assign grant = found && (!tagValid || tagAck);

  always_comb begin
    ackVec = '0;
    if (grant) begin
      ackVec[winner] = 1'b1;
    end
  end

  //////////////////////////////
  // Output register

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      tagValid <= 1'b0;
      ptr      <= '0;
    end else if (grant) begin
      tagValid <= 1'b1;
      ptr      <= winner + 1'b1;
    end else if (tagAck) begin
      tagValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      outWord <= wordVec[winner];
    end
  end

  assign tagData = outWord;

endmodule

`default_nettype wire

// ==== hw/spikeCore.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spikeDefines.svh"

// PC-to-chip spike traffic core
module spikeCore (
  input  logic                               clk,
  input  logic                               arstN,
  // PC stream, one word per cycle
  input  logic                               pcValid,
  input  logic [`PC_WIDTH-1:0]               pcData,
  // Merged tag output
  output logic                               tagValid,
  output logic [`TAG_WIDTH+`COUNT_WIDTH-1:0] tagData,
  input  logic                               tagAck
);

  //////////////////////////////
  // Internal wiring

  logic                   unitWrite;
  logic [`UNIT_WIDTH-1:0] unitLen;
  logic                   unitPulse;

  cfgBusIf     cfgBus ();
  tagChannelIf tagCh [`NUM_GENS] ();

  //////////////////////////////
  // Config path

  pcParser parser (
    .clk       (clk),
    .arstN     (arstN),
    .pcValid   (pcValid),
    .pcData    (pcData),
    .unitWrite (unitWrite),
    .unitLen   (unitLen),
    .cfg       (cfgBus)
  );

  timeMgr timer (
    .clk       (clk),
    .arstN     (arstN),
    .unitWrite (unitWrite),
    .unitLen   (unitLen),
    .unitPulse (unitPulse)
  );

  //////////////////////////////
  // Spike path

  // One generator per channel, index matches bus address
  for (genvar i = 0; i < `NUM_GENS; i++) begin : gGen
    spikeGen #(
      .genIndex (i)
    ) gen (
      .clk       (clk),
      .arstN     (arstN),
      .unitPulse (unitPulse),
      .cfg       (cfgBus),
      .tagOut    (tagCh[i])
    );
  end

  tagMerge merger (
    .clk      (clk),
    .arstN    (arstN),
    .tagIn    (tagCh),
    .tagValid (tagValid),
    .tagData  (tagData),
    .tagAck   (tagAck)
  );

endmodule

`default_nettype wire

// ==== test/spikeCoreTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spikeDefines.svh"

module spikeCoreTb;

  // Whole run is under 2000 cycles, generous margin on top
  localparam int CycleLimit = 20000;
  localparam int WordWait   = 200;
  localparam int DrainWait  = 30;

  logic                               clk;
  logic                               arstN;
  logic                               pcValid;
  logic [`PC_WIDTH-1:0]               pcData;
  logic                               tagValid;
  logic [`TAG_WIDTH+`COUNT_WIDTH-1:0] tagData;
  logic                               tagAck;

  int          errors = 0;
  int          checks = 0;
  int          cycle  = 0;
  logic [31:0] rngState;

  spikeCore dut_i (
    .clk      (clk),
    .arstN    (arstN),
    .pcValid  (pcValid),
    .pcData   (pcData),
    .tagValid (tagValid),
    .tagData  (tagData),
    .tagAck   (tagAck)
  );

  //////////////////////////////
  // Clock, cycle count, timeout

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    wait (cycle >= CycleLimit);
    $display("Timeout after %0d cycles, tests did not finish", cycle);
    $display("** FAIL **");
    $finish;
  end

  //////////////////////////////
  // Helpers

  // xorshift32 step
  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic spikePkg::tagWord_t makeWord(input logic [`TAG_WIDTH-1:0] tag,
                                                  input logic [`COUNT_WIDTH-1:0] count);
    spikePkg::tagWord_t w;
    w.tag   = tag;
    w.count = count;
    return w;
  endfunction

  // One-cycle strobe, returns on a falling edge
  task automatic sendWord(input logic [`PC_CODE_WIDTH-1:0] op, input logic [23:0] data);
    @(negedge clk);
    pcValid = 1'b1;
    pcData  = {op, data};
    @(negedge clk);
    pcValid = 1'b0;
    pcData  = '0;
  endtask

  // Index in data 23..21, value in the low bits
  task automatic setGen(input logic [`GEN_IDX_WIDTH-1:0] idx,
                        input logic [`PC_CODE_WIDTH-1:0] op, input logic [15:0] value);
    sendWord(op, {idx, 5'd0, value});
  endtask

  // Takes the word at the current falling edge, then steps past its transfer
  task automatic waitWord(input int limit, output logic found,
                          output spikePkg::tagWord_t word, output int when);
    found = 1'b0;
    word  = '0;
    when  = 0;
    for (int i = 0; i < limit && !found; i++) begin
      if (tagValid) begin
        found = 1'b1;
        word  = spikePkg::tagWord_t'(tagData);
        when  = cycle;
      end
      @(negedge clk);
    end
  endtask

  task automatic drainWords();
    logic               found;
    spikePkg::tagWord_t word;
    int                 when;
    found = 1'b1;
    while (found) begin
      waitWord(DrainWait, found, word, when);
    end
  endtask

  task automatic expectSilence(input int n, input string name);
    logic seen;
    seen = 1'b0;
    repeat (n) begin
      @(negedge clk);
      if (tagValid) begin
        seen = 1'b1;
      end
    end
    checks++;
    if (seen) begin
      errors++;
      $display("tagValid went high during %s, no output expected", name);
    end
  endtask

  task automatic reportMissing(input string name);
    errors++;
    $display("No tag word arrived within %0d cycles during %s", WordWait, name);
  endtask

  //////////////////////////////
  // Compare tasks

  task automatic checkTagWord(input string name, input spikePkg::tagWord_t got,
                              input spikePkg::tagWord_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkCount(input string name, input logic [`COUNT_WIDTH-1:0] got,
                            input logic [`COUNT_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkCycles(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  //////////////////////////////
  // Directed tests

  task automatic resetSilence();
    expectSilence(200, "idle after reset");
    // Configured but never enabled
    sendWord(spikePkg::opSetUnit, 24'd1);
    setGen(3'd0, spikePkg::opSetPeriod, 16'd2);
    setGen(3'd0, spikePkg::opSetTag, 16'h055);
    expectSilence(200, "disabled generator");
    // Enabled with period 0
    setGen(3'd1, spikePkg::opSetEnable, 16'd1);
    expectSilence(100, "zero period generator");
    // Unknown codes carrying an enable payload for generator 2
    setGen(3'd2, spikePkg::opSetPeriod, 16'd3);
    setGen(3'd2, 8'h05, 16'd1);
    setGen(3'd2, 8'h00, 16'd1);
    setGen(3'd2, 8'hff, 16'd1);
    expectSilence(200, "unknown opcodes");
    setGen(3'd1, spikePkg::opSetEnable, 16'd0);
  endtask

  task automatic singleGenerator();
    logic [31:0]           r;
    logic [`TAG_WIDTH-1:0] tag;
    logic                  found;
    spikePkg::tagWord_t    got;
    int                    when;
    int                    last;
    r    = nextRand();
    tag  = r[`TAG_WIDTH-1:0];
    last = 0;
    tagAck = 1'b1;
    sendWord(spikePkg::opSetUnit, 24'd3);
    setGen(3'd0, spikePkg::opSetPeriod, 16'd5);
    setGen(3'd0, spikePkg::opSetTag, 16'(tag));
    setGen(3'd0, spikePkg::opSetEnable, 16'd1);
    for (int k = 0; k < 5; k++) begin
      waitWord(WordWait, found, got, when);
      if (!found) begin
        reportMissing("single generator");
        break;
      end
      checkTagWord($sformatf("tagData word %0d", k), got, makeWord(tag, 1));
      // unit 3 times period 5
      if (k > 0) begin
        checkCycles("tagValid spacing", when - last, 15);
      end
      last = when;
    end
    setGen(3'd0, spikePkg::opSetEnable, 16'd0);
    drainWords();
  endtask

  task automatic backPressure();
    logic [31:0]           r;
    logic [`TAG_WIDTH-1:0] tag;
    logic                  found;
    spikePkg::tagWord_t    got;
    int                    when;
    int                    tEn;
    int                    tDis;
    int                    n;
    int                    sum;
    int                    accCount;
    int                    expected;
    r   = nextRand();
    tag = r[`TAG_WIDTH-1:0];
    n   = 0;
    sum = 0;
    accCount = 0;
    sendWord(spikePkg::opSetUnit, 24'd1);
    setGen(3'd0, spikePkg::opSetPeriod, 16'd4);
    setGen(3'd0, spikePkg::opSetTag, 16'(tag));
    tagAck = 1'b0;
    setGen(3'd0, spikePkg::opSetEnable, 16'd1);
    tEn = cycle;
    repeat (40) @(negedge clk);
    setGen(3'd0, spikePkg::opSetEnable, 16'd0);
    tDis = cycle;
    tagAck = 1'b1;
    found = 1'b1;
    while (found) begin
      waitWord(DrainWait, found, got, when);
      if (found) begin
        // First expiry lands in the empty output register
        if (n == 0) begin
          checkTagWord("tagData first word", got, makeWord(tag, 1));
        end
        // Generator's first word after release holds the stalled spikes
        if (n == 1) begin
          accCount = int'(got.count);
        end
        sum += int'(got.count);
        n++;
      end
    end
    if (n == 0) begin
      reportMissing("back-pressure");
    end
    // Ten expiries in the stall, one already taken by the output register
    checks++;
    if (accCount < 9) begin
      errors++;
      $display("Accumulated word carried only %0d spikes, at least 9 expected", accCount);
    end
    expected = (tDis - tEn) / 4;
    checks++;
    if (sum > expected + 1 || sum < expected - 1) begin
      errors++;
      $display("MISMATCH count sum: got 0x%h, expected 0x%h within one", sum, expected);
    end
  endtask

  task automatic saturation();
    logic [31:0]           r;
    logic [`TAG_WIDTH-1:0] tag;
    logic                  found;
    spikePkg::tagWord_t    got;
    int                    when;
    r   = nextRand();
    tag = r[`TAG_WIDTH-1:0];
    sendWord(spikePkg::opSetUnit, 24'd1);
    setGen(3'd0, spikePkg::opSetPeriod, 16'd1);
    setGen(3'd0, spikePkg::opSetTag, 16'(tag));
    tagAck = 1'b0;
    setGen(3'd0, spikePkg::opSetEnable, 16'd1);
    repeat (600) @(negedge clk);
    setGen(3'd0, spikePkg::opSetEnable, 16'd0);
    tagAck = 1'b1;
    // Word held in the output register since before the stall
    waitWord(WordWait, found, got, when);
    if (!found) begin
      reportMissing("saturation");
    end else begin
      checkTagWord("tagData held word", got, makeWord(tag, 1));
      waitWord(WordWait, found, got, when);
      if (!found) begin
        reportMissing("saturation");
      end else begin
        checkCount("tagData.count", got.count, 9'd511);
        checkTagWord("tagData saturated word", got, makeWord(tag, 9'd511));
      end
    end
    drainWords();
  endtask

  task automatic roundRobin();
    logic [31:0]           r;
    logic [`TAG_WIDTH-1:0] tags [4];
    logic                  found;
    spikePkg::tagWord_t    got;
    int                    when;
    // Stop pulses so all four counters start in step
    sendWord(spikePkg::opSetUnit, 24'd0);
    tagAck = 1'b1;
    for (int k = 0; k < 4; k++) begin
      r = nextRand();
      // Low bits force distinct tags
      tags[k] = {r[`TAG_WIDTH-1:3], 3'(k)};
      setGen(3'(4 + k), spikePkg::opSetPeriod, 16'd3);
      setGen(3'(4 + k), spikePkg::opSetTag, 16'(tags[k]));
      setGen(3'(4 + k), spikePkg::opSetEnable, 16'd1);
    end
    sendWord(spikePkg::opSetUnit, 24'd2);
    for (int b = 0; b < 3; b++) begin
      for (int k = 0; k < 4; k++) begin
        waitWord(WordWait, found, got, when);
        if (!found) begin
          reportMissing("round robin");
          break;
        end
        checkTagWord($sformatf("tagData burst %0d slot %0d", b, k), got, makeWord(tags[k], 1));
      end
    end
    for (int k = 0; k < 4; k++) begin
      setGen(3'(4 + k), spikePkg::opSetEnable, 16'd0);
    end
    drainWords();
  endtask

  //////////////////////////////
  // Main sequence

  initial begin
    arstN    = 1'b0;
    pcValid  = 1'b0;
    pcData   = '0;
    tagAck   = 1'b0;
    rngState = 32'd78271;
    repeat (2) @(negedge clk);
    arstN = 1'b1;

    resetSilence();
    singleGenerator();
    backPressure();
    saturation();
    roundRobin();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== spikeCore.f ====
+incdir+hw
hw/spikePkg.sv
hw/cfgBusIf.sv
hw/tagChannelIf.sv
hw/pcParser.sv
hw/timeMgr.sv
hw/spikeGen.sv
hw/tagMerge.sv
hw/spikeCore.sv
test/spikeCoreTb.sv

// ==== Makefile ====
# Verilator build and run for spikeCore

VERILATOR ?= verilator
TOP       ?= spikeCoreTb
FLIST     ?= spikeCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FLIST)) hw/spikeDefines.svh
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
